// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_copy_engine
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$($(abspath $(BIN)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/burst_mover.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module burst_mover import dm_pkg::*; (
   input  wire logic                  aclk,
   input  wire logic                  aresetn,
   input  wire logic                  start,
   input  wire logic [`DM_ADDR_W-1:0] src_base,
   input  wire logic [`DM_ADDR_W-1:0] dest_base,
   input  wire logic [`DM_ADDR_W-1:0] length,
   output logic                       done,
   output dm_addr_t                   ar,
   output logic                       ar_valid,
   input  wire logic                  ar_ready,
   input  wire dm_data_t              r,
   input  wire logic                  r_valid,
   output logic                       r_ready,
   output dm_addr_t                   aw,
   output logic                       aw_valid,
   input  wire logic                  aw_ready,
   output dm_data_t                   w,
   output logic                       w_valid,
   input  wire logic                  w_ready,
   input  wire dm_resp_t              b,
   input  wire logic                  b_valid,
   output logic                       b_ready
);

   dm_state_t             state;
   logic [`DM_ADDR_W-1:0] src_addr;
   logic [`DM_ADDR_W-1:0] dst_addr;
   logic [`DM_ADDR_W-1:0] remaining;
   logic                  ar_done;
   logic                  aw_done;

   logic [`DM_ADDR_W-1:0] beats_left;
   logic [`DM_ADDR_W-1:0] burst_beats;
   logic [`DM_ADDR_W-1:0] burst_bytes;
   logic [7:0]            burst_len;
   logic                  job_accept;
   logic                  ar_fire;
   logic                  aw_fire;
   logic                  b_fire;

   // Read data goes straight out as write data and stalls pass both ways
   assign w       = r;
   assign w_valid = r_valid;
   assign r_ready = w_ready;

   // Next burst size is capped at the maximum burst
   assign beats_left  = remaining >> `DM_BEAT_SHIFT;
   assign burst_beats = (beats_left > `DM_ADDR_W'(`DM_MAX_BEATS)) ?
                        `DM_ADDR_W'(`DM_MAX_BEATS) : beats_left;
   assign burst_bytes = burst_beats << `DM_BEAT_SHIFT;
   assign burst_len   = 8'(burst_beats - `DM_ADDR_W'(1));

   assign job_accept = (state == DM_IDLE) && done && start;
   assign ar_fire    = ar_valid && ar_ready;
   assign aw_fire    = aw_valid && aw_ready;
   assign b_fire     = b_valid && b_ready;

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         state     <= DM_IDLE;
         done      <= 1'b1;
         ar_valid  <= 1'b0;
         aw_valid  <= 1'b0;
         b_ready   <= 1'b0;
         ar_done   <= 1'b0;
         aw_done   <= 1'b0;
         remaining <= '0;
      end else begin
         case (state)
            DM_IDLE: begin
               if (!done) begin
                  // Only reached by a zero-length job
                  done <= 1'b1;
               end else if (start) begin
                  done      <= 1'b0;
                  remaining <= length;
                  if (length[`DM_ADDR_W-1:`DM_BEAT_SHIFT] != '0) begin
                     state <= DM_ISSUE;
                  end
               end
            end
            DM_ISSUE: begin
               ar_valid  <= 1'b1;
               aw_valid  <= 1'b1;
               ar_done   <= 1'b0;
               aw_done   <= 1'b0;
               remaining <= remaining - burst_bytes;
               state     <= DM_WAIT_ADDR;
            end
            DM_WAIT_ADDR: begin
               if (ar_fire) begin
                  ar_valid <= 1'b0;
                  ar_done  <= 1'b1;
               end
               if (aw_fire) begin
                  aw_valid <= 1'b0;
                  aw_done  <= 1'b1;
               end
               if ((ar_done || ar_fire) && (aw_done || aw_fire)) begin
                  b_ready <= 1'b1;
                  state   <= DM_WAIT_RESP;
               end
            end
            DM_WAIT_RESP: begin
               if (b_fire) begin
                  b_ready <= 1'b0;
                  if (remaining == '0) begin
                     done  <= 1'b1;
                     state <= DM_IDLE;
                  end else begin
                     state <= DM_ISSUE;
                  end
               end
            end
            default: state <= DM_IDLE;
         endcase
      end
   end

   // Job addresses and address channel payloads
   always_ff @(posedge aclk) begin
      if (job_accept) begin
         src_addr <= src_base;
         dst_addr <= dest_base;
      end else if (state == DM_ISSUE) begin
         ar.addr  <= {src_addr[`DM_ADDR_W-1:`DM_BEAT_SHIFT], {`DM_BEAT_SHIFT{1'b0}}};
         ar.len   <= burst_len;
         aw.addr  <= {dst_addr[`DM_ADDR_W-1:`DM_BEAT_SHIFT], {`DM_BEAT_SHIFT{1'b0}}};
         aw.len   <= burst_len;
         src_addr <= src_addr + burst_bytes;
         dst_addr <= dst_addr + burst_bytes;
      end
   end

endmodule

`default_nettype wire

// ==== design/copy_engine_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module copy_engine_top import dm_pkg::*; (
   input  wire logic                  aclk,
   input  wire logic                  aresetn,
   input  wire logic                  start,
   input  wire logic [`DM_ADDR_W-1:0] src_base,
   input  wire logic [`DM_ADDR_W-1:0] dest_base,
   input  wire logic [`DM_ADDR_W-1:0] length,
   output logic                       done,
   output dm_addr_t                   ar,
   output logic                       ar_valid,
   input  wire logic                  ar_ready,
   input  wire dm_data_t              r,
   input  wire logic                  r_valid,
   output logic                       r_ready,
   input  wire logic                  host_rd_en,
   input  wire logic [`DM_MEM_AW-1:0] host_rd_addr,
   output logic [`DM_DATA_W-1:0]      host_rd_data
);

   // Mover to scratchpad write path
   dm_addr_t aw;
   logic     aw_valid;
   logic     aw_ready;
   dm_data_t w;
   logic     w_valid;
   logic     w_ready;
   dm_resp_t b;
   logic     b_valid;
   logic     b_ready;

   burst_mover u_mover (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .start     (start),
      .src_base  (src_base),
      .dest_base (dest_base),
      .length    (length),
      .done      (done),
      .ar        (ar),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .r         (r),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .aw        (aw),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .w         (w),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .b         (b),
      .b_valid   (b_valid),
      .b_ready   (b_ready)
   );

   scratch_mem u_mem (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .aw           (aw),
      .aw_valid     (aw_valid),
      .aw_ready     (aw_ready),
      .w            (w),
      .w_valid      (w_valid),
      .w_ready      (w_ready),
      .b            (b),
      .b_valid      (b_valid),
      .b_ready      (b_ready),
      .host_rd_en   (host_rd_en),
      .host_rd_addr (host_rd_addr),
      .host_rd_data (host_rd_data)
   );

endmodule

`default_nettype wire

// ==== design/dm_cfg.svh ====
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// Byte address and byte length width
`define DM_ADDR_W 32

// One data beat, and log2 of its size in bytes
`define DM_DATA_W 64
`define DM_BEAT_SHIFT 3

// Longest burst the mover issues, in beats
`define DM_MAX_BEATS 256

// Scratchpad depth in words and its word index width
`define DM_MEM_WORDS 1024
`define DM_MEM_AW ($clog2(`DM_MEM_WORDS))

`endif

// ==== design/dm_pkg.sv ====
`default_nettype none

`include "dm_cfg.svh"

package dm_pkg;

   // Address channel payload, shared by the read and write sides
   // len holds beats minus one
   typedef struct packed {
      logic [`DM_ADDR_W-1:0] addr;
      logic [7:0]            len;
   } dm_addr_t;

   // One data beat with its end-of-burst flag
   typedef struct packed {
      logic [`DM_DATA_W-1:0] data;
      logic                  last;
   } dm_data_t;

   // Write response code
   typedef struct packed {
      logic [1:0] resp;
   } dm_resp_t;

   localparam logic [1:0] DM_RESP_OKAY = 2'b00;

   // Mover sequencing
   typedef enum logic [1:0] {
      DM_IDLE,
      DM_ISSUE,
      DM_WAIT_ADDR,
      DM_WAIT_RESP
   } dm_state_t;

   // Scratchpad write-side sequencing
   typedef enum logic [1:0] {
      MEM_ADDR,
      MEM_DATA,
      MEM_RESP
   } mem_state_t;

endpackage

`default_nettype wire

// ==== design/scratch_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module scratch_mem import dm_pkg::*; (
   input  wire logic                  aclk,
   input  wire logic                  aresetn,
   input  wire dm_addr_t              aw,
   input  wire logic                  aw_valid,
   output logic                       aw_ready,
   input  wire dm_data_t              w,
   input  wire logic                  w_valid,
   output logic                       w_ready,
   output dm_resp_t                   b,
   output logic                       b_valid,
   input  wire logic                  b_ready,
   input  wire logic                  host_rd_en,
   input  wire logic [`DM_MEM_AW-1:0] host_rd_addr,
   output logic [`DM_DATA_W-1:0]      host_rd_data
);

   mem_state_t            state;
   logic [`DM_MEM_AW-1:0] wr_ptr;
   logic [`DM_DATA_W-1:0] mem [`DM_MEM_WORDS];

   logic                  aw_fire;
   logic                  w_fire;
   logic                  b_fire;

   // Channel readies follow the state directly
   assign aw_ready = (state == MEM_ADDR);
   assign w_ready  = (state == MEM_DATA);
   assign b_valid  = (state == MEM_RESP);
   assign b.resp   = DM_RESP_OKAY;

   assign aw_fire = aw_valid && aw_ready;
   assign w_fire  = w_valid && w_ready;
   assign b_fire  = b_valid && b_ready;

   always_ff @(posedge aclk or negedge aresetn) begin
      if (!aresetn) begin
         state  <= MEM_ADDR;
         wr_ptr <= '0;
      end else begin
         case (state)
            MEM_ADDR: begin
               if (aw_fire) begin
                  // Byte address to word index
                  wr_ptr <= aw.addr[`DM_BEAT_SHIFT +: `DM_MEM_AW];
                  state  <= MEM_DATA;
               end
            end
            MEM_DATA: begin
               if (w_fire) begin
                  wr_ptr <= wr_ptr + 1'b1;
                  if (w.last) begin
                     state <= MEM_RESP;
                  end
               end
            end
            MEM_RESP: begin
               if (b_fire) begin
                  state <= MEM_ADDR;
               end
            end
            default: state <= MEM_ADDR;
         endcase
      end
   end

   // Beat lands in the cycle of its handshake
   always_ff @(posedge aclk) begin
      if (w_fire) begin
         mem[wr_ptr] <= w.data;
      end
   end

   // Host read, one cycle latency, independent of the bus side
   always_ff @(posedge aclk) begin
      if (host_rd_en) begin
         host_rd_data <= mem[host_rd_addr];
      end
   end

endmodule

`default_nettype wire

// ==== dv/copy_engine_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module copy_engine_props import dm_pkg::*; (
   input wire logic     aclk,
   input wire logic     aresetn,
   input wire logic     done,
   input wire dm_addr_t ar,
   input wire logic     ar_valid,
   input wire logic     ar_ready,
   input wire dm_addr_t aw,
   input wire logic     aw_valid,
   input wire logic     aw_ready,
   input wire logic     r_valid,
   input wire logic     w_valid
);

   int fail_count = 0;

   // Address requests hold until accepted
   ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar))
      else begin
         fail_count++;
         $error("read address dropped or changed before its handshake");
      end

   aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else begin
         fail_count++;
         $error("write address dropped or changed before its handshake");
      end

   // Data passthrough
   w_follows_r: assert property (@(posedge aclk) disable iff (!aresetn)
      w_valid == r_valid)
      else begin
         fail_count++;
         $error("write data valid differs from read data valid");
      end

   // No read request outside a job
   ar_only_busy: assert property (@(posedge aclk) disable iff (!aresetn)
      ar_valid |-> !done)
      else begin
         fail_count++;
         $error("read address issued while done is high");
      end

endmodule

bind burst_mover copy_engine_props u_props (
   .aclk     (aclk),
   .aresetn  (aresetn),
   .done     (done),
   .ar       (ar),
   .ar_valid (ar_valid),
   .ar_ready (ar_ready),
   .aw       (aw),
   .aw_valid (aw_valid),
   .aw_ready (aw_ready),
   .r_valid  (r_valid),
   .w_valid  (w_valid)
);

`default_nettype wire

// ==== dv/tb_copy_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dm_cfg.svh"

module tb_copy_engine import dm_pkg::*; ();

   localparam int SRC_WORDS = 2048;
   localparam int MEM_WORDS = `DM_MEM_WORDS;
   localparam int MEM_AW    = `DM_MEM_AW;
   localparam int MAX_BEATS = `DM_MAX_BEATS;
   localparam int N_JOBS    = 16;
   localparam int ZERO_JOB  = 12;
   localparam int POKE_JOB  = 13;

   logic                  aclk;
   logic                  aresetn;
   logic                  start;
   logic [`DM_ADDR_W-1:0] src_base;
   logic [`DM_ADDR_W-1:0] dest_base;
   logic [`DM_ADDR_W-1:0] length;
   logic                  done;
   dm_addr_t              ar;
   logic                  ar_valid;
   logic                  ar_ready;
   dm_data_t              r;
   logic                  r_valid;
   logic                  r_ready;
   logic                  host_rd_en;
   logic [MEM_AW-1:0]     host_rd_addr;
   logic [`DM_DATA_W-1:0] host_rd_data;

   logic [`DM_DATA_W-1:0] src_mem [SRC_WORDS];
   logic [`DM_DATA_W-1:0] exp_mem [MEM_WORDS];
   bit                    written [MEM_WORDS];
   int                    job_src [N_JOBS];
   int                    job_dst [N_JOBS];
   int                    job_beats [N_JOBS];

   int                    error_count = 0;
   int                    cycle_count = 0;
   int                    cycle_limit = 2000;
   int                    ar_count = 0;
   int                    exp_beats_left = 0;
   logic [`DM_ADDR_W-1:0] exp_ar_addr = '0;

   copy_engine_top dut (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .start        (start),
      .src_base     (src_base),
      .dest_base    (dest_base),
      .length       (length),
      .done         (done),
      .ar           (ar),
      .ar_valid     (ar_valid),
      .ar_ready     (ar_ready),
      .r            (r),
      .r_valid      (r_valid),
      .r_ready      (r_ready),
      .host_rd_en   (host_rd_en),
      .host_rd_addr (host_rd_addr),
      .host_rd_data (host_rd_data)
   );

   initial begin
      aclk = 1'b0;
      forever #10 aclk = ~aclk;
   end

   task automatic compare_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] got);
      assert (got === exp_v) else begin
         $display("[FAIL] %0t ns %s: expected %h, got %h", $time, name, exp_v, got);
         error_count++;
      end
   endtask

   task automatic report_error(input string what);
      $display("[ERROR] %0t ns %s", $time, what);
      error_count++;
   endtask

   // Every drive happens 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge aclk);
      #2;
   endtask

   // Reads a word range over the host port one word per cycle
   task automatic verify_image(input int first, input int count);
      host_rd_en = 1'b1;
      for (int i = first; i < first + count; i++) begin
         host_rd_addr = MEM_AW'(i);
         next_cycle();
         if (written[i]) begin
            compare_value($sformatf("host_rd_data[%0d]", i), exp_mem[i], host_rd_data);
         end
      end
      host_rd_en = 1'b0;
   endtask

   task automatic run_job(input int j);
      int wait_cycles;
      int ar_before;
      int bursts;
      compare_value("done", 1, done);
      exp_ar_addr    = 32'(job_src[j] * 8);
      exp_beats_left = job_beats[j];
      ar_before      = ar_count;
      bursts         = (job_beats[j] + MAX_BEATS - 1) / MAX_BEATS;
      src_base       = 32'(job_src[j] * 8);
      dest_base      = 32'(job_dst[j] * 8);
      length         = 32'(job_beats[j] * 8);
      start          = 1'b1;
      next_cycle();
      start = 1'b0;
      compare_value("done", 0, done);
      wait_cycles = 0;
      while (!done) begin
         // A stray start in the middle of a job
         if (j == POKE_JOB && wait_cycles == 3) begin
            src_base  = 32'h40;
            dest_base = 32'h0;
            length    = 32'h20;
            start     = 1'b1;
         end else begin
            start = 1'b0;
         end
         next_cycle();
         wait_cycles++;
      end
      start = 1'b0;
      assert (exp_beats_left == 0) else begin
         report_error("job ended before the whole source range was read");
      end
      for (int i = 0; i < job_beats[j]; i++) begin
         exp_mem[job_dst[j] + i] = src_mem[job_src[j] + i];
         written[job_dst[j] + i] = 1'b1;
      end
      if (j == ZERO_JOB) begin
         compare_value("zero-length done low cycles", 1, wait_cycles);
         verify_image(0, MEM_WORDS);
      end else begin
         verify_image(job_dst[j], job_beats[j]);
      end
      if (j == POKE_JOB) begin
         repeat (4) next_cycle();
         compare_value("done", 1, done);
      end
      compare_value("read burst count", bursts, ar_count - ar_before);
   endtask

   // Source bus model with random ar_ready and read data gaps
   initial begin : source_model
      logic                  ar_hs;
      logic                  r_hs;
      logic [`DM_ADDR_W-1:0] ar_addr_s;
      logic [7:0]            ar_len_s;
      int                    beat;
      int                    burst_beats;
      int                    bq_addr [$];
      int                    bq_len [$];
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      r        = '0;
      beat     = 0;
      forever begin
         // Sample handshakes where everything is settled
         @(negedge aclk);
         ar_hs     = ar_valid && ar_ready;
         r_hs      = r_valid && r_ready;
         ar_addr_s = ar.addr;
         ar_len_s  = ar.len;
         next_cycle();
         if (ar_hs) begin
            ar_count++;
            assert (exp_beats_left > 0) else begin
               report_error("read burst issued with no bytes left in the job");
            end
            burst_beats = (exp_beats_left > MAX_BEATS) ? MAX_BEATS : exp_beats_left;
            compare_value("ar.addr", exp_ar_addr, ar_addr_s);
            compare_value("ar.len", burst_beats - 1, ar_len_s);
            exp_ar_addr    = exp_ar_addr + 32'(burst_beats * 8);
            exp_beats_left = exp_beats_left - burst_beats;
            bq_addr.push_back(int'(ar_addr_s >> `DM_BEAT_SHIFT));
            bq_len.push_back(int'(ar_len_s));
         end
         if (r_hs) begin
            if (beat == bq_len[0]) begin
               void'(bq_addr.pop_front());
               void'(bq_len.pop_front());
               beat = 0;
            end else begin
               beat++;
            end
         end
         ar_ready = ($urandom % 4) != 0;
         if (r_valid && !r_hs) begin
            // Pending beat holds until taken
            r_valid = 1'b1;
         end else if (bq_addr.size() > 0 && ($urandom % 3) != 0) begin
            r_valid = 1'b1;
            r.data  = src_mem[bq_addr[0] + beat];
            r.last  = (beat == bq_len[0]);
         end else begin
            r_valid = 1'b0;
         end
      end
   end

   initial begin : watchdog
      while (cycle_count <= cycle_limit) begin
         @(posedge aclk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      error_count++;
      error_count += dut.u_mover.u_props.fail_count;
      $display("Errors: %0d", error_count);
      $display("Done: errors found");
      $finish;
   end

   initial begin : main
      int beats;
      int total_beats;
      void'($urandom(21727));
      aresetn      = 1'b0;
      start        = 1'b0;
      src_base     = '0;
      dest_base    = '0;
      length       = '0;
      host_rd_en   = 1'b0;
      host_rd_addr = '0;
      for (int i = 0; i < SRC_WORDS; i++) begin
         src_mem[i] = {$urandom, $urandom};
      end

      // Short, long, zero-length, stray-start and overlapping jobs
      total_beats = 0;
      for (int j = 0; j < N_JOBS; j++) begin
         if (j < 8) begin
            beats = 1 + int'($urandom % 16);
         end else if (j == ZERO_JOB) begin
            beats = 0;
         end else if (j <= POKE_JOB) begin
            beats = 300 + int'($urandom % 401);
         end else begin
            beats = 20 + int'($urandom % 21);
         end
         job_beats[j] = beats;
         job_src[j]   = int'($urandom % (SRC_WORDS - beats + 1));
         job_dst[j]   = int'($urandom % (MEM_WORDS - beats + 1));
         total_beats += beats;
      end
      job_dst[14] = int'($urandom % (MEM_WORDS - 96));
      job_dst[15] = job_dst[14] + 8;
      cycle_limit = 20 * total_beats + 2000;

      repeat (8) @(posedge aclk);
      #2;
      aresetn = 1'b1;
      compare_value("done", 1, done);
      compare_value("ar_valid", 0, ar_valid);

      for (int j = 0; j < N_JOBS; j++) begin
         run_job(j);
      end
      // Later overlapping writes must win
      verify_image(0, MEM_WORDS);

      error_count += dut.u_mover.u_props.fail_count;
      $display("Errors: %0d", error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/dm_pkg.sv
design/burst_mover.sv
design/scratch_mem.sv
design/copy_engine_top.sv
dv/copy_engine_props.sv
dv/tb_copy_engine.sv
